//--- hdl/w3d_interconnect_pkg.sv
package w3d_interconnect_pkg;

	// host DRAM window covers 0x0000_0000..0x1fff_ffff
	localparam logic [31:0] DRAM_BASE = 32'h0000_0000;
	localparam logic [31:0] DRAM_MASK = 32'he000_0000;

	// the three control regions share one mask, the external window is wider
	localparam logic [31:0] MMIO_GFX_BASE    = 32'h2000_0000;
	localparam logic [31:0] MMIO_VDC_BASE    = 32'h2400_0000;
	localparam logic [31:0] MMIO_SGDMA_BASE  = 32'h2800_0000;
	localparam logic [31:0] MMIO_REGION_MASK = 32'hfc00_0000;
	localparam logic [31:0] MMIO_EXT_BASE    = 32'h3000_0000;
	localparam logic [31:0] MMIO_EXT_MASK    = 32'hf000_0000;

	// graphics masters only reach 0x1c00_0000 and above
	localparam logic [5:0] VRAM_PREFIX = 6'b000111;

	// read data for a host access that hits no window
	localparam logic [31:0] UNMAPPED_DATA = 32'hdead_beef;

	localparam int N_MMIO = 4;

	typedef enum logic [2:0] {
		TGT_DRAM,
		TGT_GFX,
		TGT_VDC,
		TGT_SGDMA,
		TGT_EXT,
		TGT_NONE
	} target_e;

	// tag carried with each DRAM request so the response finds its owner
	typedef enum logic [1:0] {
		MST_VDC,
		MST_HOST,
		MST_GFX
	} master_e;

endpackage

//--- hdl/w3d_host_decode.sv
`timescale 1ns/1ns

module w3d_host_decode
	import w3d_interconnect_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	input  logic        host_valid,
	output logic        host_ready,
	input  logic        host_write,
	input  logic [31:0] host_addr,
	input  logic [31:0] host_wdata,

	output logic        dec_valid,
	input  logic        dec_ready,
	output logic        dec_write,
	output logic [31:0] dec_addr,
	output logic [31:0] dec_wdata,
	output target_e     dec_target
);

	// the narrow control regions are tested before the external window
	function automatic target_e classify(logic [31:0] addr);
		target_e tgt;
		if ((addr & DRAM_MASK) == DRAM_BASE)
			tgt = TGT_DRAM;
		else if ((addr & MMIO_REGION_MASK) == MMIO_GFX_BASE)
			tgt = TGT_GFX;
		else if ((addr & MMIO_REGION_MASK) == MMIO_VDC_BASE)
			tgt = TGT_VDC;
		else if ((addr & MMIO_REGION_MASK) == MMIO_SGDMA_BASE)
			tgt = TGT_SGDMA;
		else if ((addr & MMIO_EXT_MASK) == MMIO_EXT_BASE)
			tgt = TGT_EXT;
		else
			tgt = TGT_NONE;
		return tgt;
	endfunction

	logic take;

	// the slot refills in the same cycle that dispatch drains it
	assign host_ready = !dec_valid || dec_ready;
	assign take = host_valid && host_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else if (take)
			dec_valid <= 1'b1;
		else if (dec_ready)
			dec_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			dec_write  <= host_write;
			dec_addr   <= host_addr;
			dec_wdata  <= host_wdata;
			dec_target <= classify(host_addr);
		end
	end

endmodule

//--- hdl/w3d_host_dispatch.sv
`timescale 1ns/1ns

module w3d_host_dispatch
	import w3d_interconnect_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,

	input  logic                    dec_valid,
	output logic                    dec_ready,
	input  logic                    dec_write,
	input  logic [31:0]             dec_addr,
	input  logic [31:0]             dec_wdata,
	input  target_e                 dec_target,

	output logic [N_MMIO-1:0]       mmio_valid,
	input  logic [N_MMIO-1:0]       mmio_ready,
	output logic                    mmio_write,
	output logic [31:0]             mmio_addr,
	output logic [31:0]             mmio_wdata,
	input  logic [N_MMIO-1:0]       mmio_rvalid,
	input  logic [N_MMIO-1:0][31:0] mmio_rdata,
	output logic                    mmio_rready,

	output logic                    hreq_valid,
	input  logic                    hreq_ready,
	output logic                    hreq_write,
	output logic [31:0]             hreq_addr,
	output logic [31:0]             hreq_wdata,
	input  logic                    hrsp_valid,
	input  logic [31:0]             hrsp_data,

	output logic                    host_rvalid,
	input  logic                    host_rready,
	output logic [31:0]             host_rdata,
	output logic                    host_rerr
);

	typedef enum logic [1:0] {IDLE, ISSUE, WAIT, RESP} state_e;

	state_e      state;
	logic        req_write;
	logic [31:0] req_addr;
	logic [31:0] req_wdata;
	target_e     req_target;
	logic [31:0] rsp_data;
	logic        rsp_err;

	logic              is_mmio;
	logic [1:0]        mmio_idx;
	logic [N_MMIO-1:0] mmio_sel;
	logic              issue_done;
	logic              rsp_hit;
	logic [31:0]       rsp_in;

	// one-hot bit order follows the region order gfx, vdc, sgdma, ext
	always_comb begin
		is_mmio  = 1'b1;
		mmio_idx = 2'd0;
		case (req_target)
			TGT_GFX:   mmio_idx = 2'd0;
			TGT_VDC:   mmio_idx = 2'd1;
			TGT_SGDMA: mmio_idx = 2'd2;
			TGT_EXT:   mmio_idx = 2'd3;
			default:   is_mmio = 1'b0;
		endcase
	end

	assign mmio_sel = is_mmio ? {{(N_MMIO-1){1'b0}}, 1'b1} << mmio_idx : '0;

	assign dec_ready   = state == IDLE;
	assign mmio_valid  = (state == ISSUE) ? mmio_sel : '0;
	assign hreq_valid  = state == ISSUE && req_target == TGT_DRAM;
	assign mmio_rready = state == WAIT;
	assign host_rvalid = state == RESP;

	assign mmio_write = req_write;
	assign mmio_addr  = req_addr;
	assign mmio_wdata = req_wdata;
	assign hreq_write = req_write;
	assign hreq_addr  = req_addr;
	assign hreq_wdata = req_wdata;
	assign host_rdata = rsp_data;
	assign host_rerr  = rsp_err;

	assign issue_done = |(mmio_valid & mmio_ready) || (hreq_valid && hreq_ready);
	assign rsp_hit    = is_mmio ? mmio_rvalid[mmio_idx] : hrsp_valid;
	assign rsp_in     = is_mmio ? mmio_rdata[mmio_idx] : hrsp_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:
					if (dec_valid) begin
						if (dec_target == TGT_NONE)
							state <= RESP;
						else
							state <= ISSUE;
					end
				ISSUE: if (issue_done) state <= WAIT;
				WAIT:  if (rsp_hit) state <= RESP;
				RESP:  if (host_rready) state <= IDLE;
			endcase
		end
	end

	// unmapped requests keep the error word loaded at acceptance
	always_ff @(posedge clk) begin
		if (dec_valid && dec_ready) begin
			req_write  <= dec_write;
			req_addr   <= dec_addr;
			req_wdata  <= dec_wdata;
			req_target <= dec_target;
			rsp_data   <= UNMAPPED_DATA;
			rsp_err    <= dec_target == TGT_NONE;
		end else if (state == WAIT && rsp_hit) begin
			rsp_data <= req_write ? 32'd0 : rsp_in;
		end
	end

endmodule

//--- hdl/w3d_dram_arbiter.sv
`timescale 1ns/1ns

module w3d_dram_arbiter
	import w3d_interconnect_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	input  logic        vdc_stream_valid,
	output logic        vdc_stream_ready,
	input  logic        vdc_stream_write,
	input  logic [31:0] vdc_stream_addr,
	input  logic [31:0] vdc_stream_wdata,
	output logic        vdc_stream_rvalid,
	output logic [31:0] vdc_stream_rdata,

	input  logic        hreq_valid,
	output logic        hreq_ready,
	input  logic        hreq_write,
	input  logic [31:0] hreq_addr,
	input  logic [31:0] hreq_wdata,
	output logic        hrsp_valid,
	output logic [31:0] hrsp_data,

	input  logic        gfx_vram_valid,
	output logic        gfx_vram_ready,
	input  logic        gfx_vram_write,
	input  logic [31:0] gfx_vram_addr,
	input  logic [31:0] gfx_vram_wdata,
	output logic        gfx_vram_rvalid,
	output logic [31:0] gfx_vram_rdata,

	output logic        dram_valid,
	input  logic        dram_ready,
	output logic        dram_write,
	output logic [31:0] dram_addr,
	output logic [31:0] dram_wdata,
	output master_e     dram_tag,
	input  logic        dram_rvalid,
	input  master_e     dram_rtag,
	input  logic [31:0] dram_rdata
);

	function automatic logic [31:0] vram_addr(logic [31:0] addr);
		return {VRAM_PREFIX, addr[25:0]};
	endfunction

	master_e     grant;
	logic        rsp_valid;
	master_e     rsp_tag;
	logic [31:0] rsp_data;

	// display refill must not starve, so vdc always wins
	always_comb begin
		if (vdc_stream_valid)
			grant = MST_VDC;
		else if (hreq_valid)
			grant = MST_HOST;
		else
			grant = MST_GFX;
	end

	always_comb begin
		case (grant)
			MST_VDC: begin
				dram_write = vdc_stream_write;
				dram_addr  = vram_addr(vdc_stream_addr);
				dram_wdata = vdc_stream_wdata;
			end
			MST_HOST: begin
				dram_write = hreq_write;
				dram_addr  = hreq_addr;
				dram_wdata = hreq_wdata;
			end
			default: begin
				dram_write = gfx_vram_write;
				dram_addr  = vram_addr(gfx_vram_addr);
				dram_wdata = gfx_vram_wdata;
			end
		endcase
	end

	assign dram_valid = vdc_stream_valid || hreq_valid || gfx_vram_valid;
	assign dram_tag   = grant;

	assign vdc_stream_ready = dram_ready && grant == MST_VDC;
	assign hreq_ready       = dram_ready && grant == MST_HOST;
	assign gfx_vram_ready   = dram_ready && grant == MST_GFX;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= dram_rvalid;
	end

	always_ff @(posedge clk) begin
		if (dram_rvalid) begin
			rsp_tag  <= dram_rtag;
			rsp_data <= dram_rdata;
		end
	end

	// each master sees a one-cycle pulse when its tag comes back
	assign vdc_stream_rvalid = rsp_valid && rsp_tag == MST_VDC;
	assign hrsp_valid        = rsp_valid && rsp_tag == MST_HOST;
	assign gfx_vram_rvalid   = rsp_valid && rsp_tag == MST_GFX;

	assign vdc_stream_rdata = rsp_data;
	assign hrsp_data        = rsp_data;
	assign gfx_vram_rdata   = rsp_data;

endmodule

//--- hdl/w3d_interconnect.sv
`timescale 1ns/1ns

module w3d_interconnect
	import w3d_interconnect_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,

	input  logic                    host_valid,
	output logic                    host_ready,
	input  logic                    host_write,
	input  logic [31:0]             host_addr,
	input  logic [31:0]             host_wdata,
	output logic                    host_rvalid,
	input  logic                    host_rready,
	output logic [31:0]             host_rdata,
	output logic                    host_rerr,

	output logic [N_MMIO-1:0]       mmio_valid,
	input  logic [N_MMIO-1:0]       mmio_ready,
	output logic                    mmio_write,
	output logic [31:0]             mmio_addr,
	output logic [31:0]             mmio_wdata,
	input  logic [N_MMIO-1:0]       mmio_rvalid,
	input  logic [N_MMIO-1:0][31:0] mmio_rdata,
	output logic                    mmio_rready,

	input  logic                    gfx_vram_valid,
	output logic                    gfx_vram_ready,
	input  logic                    gfx_vram_write,
	input  logic [31:0]             gfx_vram_addr,
	input  logic [31:0]             gfx_vram_wdata,
	output logic                    gfx_vram_rvalid,
	output logic [31:0]             gfx_vram_rdata,

	input  logic                    vdc_stream_valid,
	output logic                    vdc_stream_ready,
	input  logic                    vdc_stream_write,
	input  logic [31:0]             vdc_stream_addr,
	input  logic [31:0]             vdc_stream_wdata,
	output logic                    vdc_stream_rvalid,
	output logic [31:0]             vdc_stream_rdata,

	output logic                    dram_valid,
	input  logic                    dram_ready,
	output logic                    dram_write,
	output logic [31:0]             dram_addr,
	output logic [31:0]             dram_wdata,
	output master_e                 dram_tag,
	input  logic                    dram_rvalid,
	input  master_e                 dram_rtag,
	input  logic [31:0]             dram_rdata
);

	logic        dec_valid;
	logic        dec_ready;
	logic        dec_write;
	logic [31:0] dec_addr;
	logic [31:0] dec_wdata;
	target_e     dec_target;

	// host path into the arbiter
	logic        hreq_valid;
	logic        hreq_ready;
	logic        hreq_write;
	logic [31:0] hreq_addr;
	logic [31:0] hreq_wdata;
	logic        hrsp_valid;
	logic [31:0] hrsp_data;

	w3d_host_decode u_decode (.*);

	w3d_host_dispatch u_dispatch (.*);

	w3d_dram_arbiter u_arbiter (.*);

endmodule

//--- tb/tb_w3d_interconnect.sv
`timescale 1ns/1ns

module tb_w3d_interconnect
	import w3d_interconnect_pkg::*;
();

	logic                    clk;
	logic                    rst_n;
	logic                    host_valid, host_ready, host_write;
	logic [31:0]             host_addr, host_wdata, host_rdata;
	logic                    host_rvalid, host_rready, host_rerr;
	logic [N_MMIO-1:0]       mmio_valid, mmio_ready, mmio_rvalid;
	logic                    mmio_write, mmio_rready;
	logic [31:0]             mmio_addr, mmio_wdata;
	logic [N_MMIO-1:0][31:0] mmio_rdata;
	logic                    gfx_vram_valid, gfx_vram_ready, gfx_vram_write, gfx_vram_rvalid;
	logic [31:0]             gfx_vram_addr, gfx_vram_wdata, gfx_vram_rdata;
	logic                    vdc_stream_valid, vdc_stream_ready, vdc_stream_write;
	logic                    vdc_stream_rvalid;
	logic [31:0]             vdc_stream_addr, vdc_stream_wdata, vdc_stream_rdata;
	logic                    dram_valid, dram_ready, dram_write, dram_rvalid;
	logic [31:0]             dram_addr, dram_wdata, dram_rdata;
	master_e                 dram_tag, dram_rtag;

	integer      seed;
	logic [31:0] shadow_dram [logic [31:0]];
	logic [31:0] dram_mem [logic [31:0]];
	logic [31:0] shadow_mmio [N_MMIO][16];
	logic [31:0] mmio_regs [N_MMIO][16];
	logic [32:0] exp_q [$];
	master_e     accept_log [$];
	master_e     pend_tag [$];
	logic [31:0] pend_data [$];
	int          pend_delay [$];
	int          req_count, rsp_count, dram_valids, mmio_valids, cycles, limit;
	logic        rready_random, dram_hold;
	string       cur_test;
	logic        d_acc, d_write, m_write;
	logic [31:0] d_addr, d_wdata, m_addr, m_wdata;
	master_e     d_tag;
	logic [N_MMIO-1:0] m_acc, m_done;

	w3d_interconnect u_w3d_interconnect (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// -1 is DRAM, 0..3 the MMIO regions in gfx, vdc, sgdma, ext order, 4 unmapped
	function automatic int region_of(input logic [31:0] addr);
		if ((addr & DRAM_MASK) == DRAM_BASE) return -1;
		if ((addr & MMIO_REGION_MASK) == MMIO_GFX_BASE) return 0;
		if ((addr & MMIO_REGION_MASK) == MMIO_VDC_BASE) return 1;
		if ((addr & MMIO_REGION_MASK) == MMIO_SGDMA_BASE) return 2;
		if ((addr & MMIO_EXT_MASK) == MMIO_EXT_BASE) return 3;
		return 4;
	endfunction

	// never written DRAM words read back as this address-dependent pattern
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return addr ^ 32'h5a5a_a5a5;
	endfunction

	// expected {rerr, rdata} of one access
	function automatic logic [32:0] expect_rsp(input logic write, input logic [31:0] addr);
		int r;
		r = region_of(addr);
		if (r == 4) return {1'b1, UNMAPPED_DATA};
		if (write) return 33'd0;
		if (r < 0) return {1'b0, shadow_dram.exists(addr) ? shadow_dram[addr] : fill_word(addr)};
		return {1'b0, shadow_mmio[r][addr[5:2]]};
	endfunction

	task automatic record_write(input logic [31:0] addr, input logic [31:0] wdata);
		int r;
		r = region_of(addr);
		if (r < 0)
			shadow_dram[addr] = wdata;
		else if (r < 4)
			shadow_mmio[r][addr[5:2]] = wdata;
	endtask

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error %s %s: expected %h, actual %h", cur_test, name, expected, actual);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout after %0d cycles with %0d responses outstanding", cycles,
				req_count - rsp_count);
			$display("Checks failed");
			$fatal(1);
		end
	end

	always @(posedge clk) begin
		dram_ready  <= dram_hold ? 1'b0 : (($random(seed) & 3) != 0);
		host_rready <= rready_random ? (($random(seed) & 1) != 0) : 1'b1;
	end

	// sample handshakes mid-cycle where every DUT output is settled
	always @(negedge clk) begin
		d_acc   = dram_valid && dram_ready;
		d_write = dram_write;
		d_addr  = dram_addr;
		d_wdata = dram_wdata;
		d_tag   = dram_tag;
		m_acc   = mmio_valid & mmio_ready;
		m_done  = mmio_rvalid & {N_MMIO{mmio_rready}};
		m_write = mmio_write;
		m_addr  = mmio_addr;
		m_wdata = mmio_wdata;
		if (dram_valid)
			dram_valids++;
		if (|mmio_valid)
			mmio_valids++;
		check("mmio_onehot", 32'd0, {31'd0, $countones(mmio_valid) > 1});
	end

	// DRAM answers after 1 to 4 cycles, picking a random ready entry
	always @(posedge clk) begin
		int idx;
		int start;
		if (d_acc) begin
			accept_log.push_back(d_tag);
			if (d_tag != MST_HOST)
				check("vram_prefix", {26'd0, VRAM_PREFIX}, {26'd0, d_addr[31:26]});
			pend_tag.push_back(d_tag);
			if (d_write) begin
				dram_mem[d_addr] = d_wdata;
				pend_data.push_back(32'd0);
			end else begin
				pend_data.push_back(dram_mem.exists(d_addr) ? dram_mem[d_addr] : fill_word(d_addr));
			end
			pend_delay.push_back(1 + ($random(seed) & 3));
		end
		idx = -1;
		if (pend_tag.size() > 0) begin
			start = $unsigned($random(seed)) % pend_tag.size();
			for (int i = 0; i < pend_tag.size(); i++)
				if (idx < 0 && pend_delay[(start + i) % pend_tag.size()] <= 0)
					idx = (start + i) % pend_tag.size();
		end
		if (idx >= 0) begin
			dram_rvalid <= 1'b1;
			dram_rtag   <= pend_tag[idx];
			dram_rdata  <= pend_data[idx];
			pend_tag.delete(idx);
			pend_data.delete(idx);
			pend_delay.delete(idx);
		end else begin
			dram_rvalid <= 1'b0;
		end
		foreach (pend_delay[i])
			pend_delay[i]--;
	end

	always @(posedge clk) begin
		for (int i = 0; i < N_MMIO; i++) begin
			if (m_done[i])
				mmio_rvalid[i] <= 1'b0;
			if (m_acc[i]) begin
				if (m_write)
					mmio_regs[i][m_addr[5:2]] = m_wdata;
				mmio_rdata[i]  <= m_write ? 32'd0 : mmio_regs[i][m_addr[5:2]];
				mmio_rvalid[i] <= 1'b1;
			end
			mmio_ready[i] <= ($random(seed) & 1) != 0;
		end
	end

	always @(negedge clk) begin
		logic [32:0] exp;
		if (host_rvalid && host_rready) begin
			if (exp_q.size() == 0) begin
				$display("host response arrived with no request outstanding");
				$display("Checks failed");
				$fatal(1);
			end else begin
				exp = exp_q.pop_front();
				check("host_rdata", exp[31:0], host_rdata);
				check("host_rerr", {31'd0, exp[32]}, {31'd0, host_rerr});
				rsp_count++;
			end
		end
	end

	task automatic host_req(input logic write, input logic [31:0] addr, input logic [31:0] wdata);
		@(posedge clk);
		host_valid <= 1'b1;
		host_write <= write;
		host_addr  <= addr;
		host_wdata <= wdata;
		@(negedge clk);
		while (!host_ready)
			@(negedge clk);
		exp_q.push_back(expect_rsp(write, addr));
		if (write)
			record_write(addr, wdata);
		req_count++;
		@(posedge clk);
		host_valid <= 1'b0;
	endtask

	task automatic master_access(input logic is_gfx, input logic write,
		input logic [31:0] addr, input logic [31:0] wdata);
		logic [31:0] vaddr;
		logic [32:0] exp;
		vaddr = {VRAM_PREFIX, addr[25:0]};
		@(posedge clk);
		if (is_gfx) begin
			gfx_vram_valid <= 1'b1;
			gfx_vram_write <= write;
			gfx_vram_addr  <= addr;
			gfx_vram_wdata <= wdata;
		end else begin
			vdc_stream_valid <= 1'b1;
			vdc_stream_write <= write;
			vdc_stream_addr  <= addr;
			vdc_stream_wdata <= wdata;
		end
		@(negedge clk);
		while (!(is_gfx ? gfx_vram_ready : vdc_stream_ready))
			@(negedge clk);
		exp = expect_rsp(write, vaddr);
		if (write)
			record_write(vaddr, wdata);
		@(posedge clk);
		if (is_gfx)
			gfx_vram_valid <= 1'b0;
		else
			vdc_stream_valid <= 1'b0;
		@(negedge clk);
		while (!(is_gfx ? gfx_vram_rvalid : vdc_stream_rvalid))
			@(negedge clk);
		if (!write)
			check(is_gfx ? "gfx_rdata" : "vdc_rdata", exp[31:0],
				is_gfx ? gfx_vram_rdata : vdc_stream_rdata);
	endtask

	// the response count only moves on the falling edge
	task automatic drain();
		while (rsp_count != req_count)
			@(posedge clk);
		@(negedge clk);
	endtask

	initial begin
		logic [31:0] addrs [12];
		logic [31:0] gaddr [3];
		logic [31:0] vaddr [3];
		logic [31:0] bases [4];
		int          saved_dram;
		int          saved_mmio;
		int          sel;
		seed = 32'h9b48_85ec;
		bases = '{32'h2000_0000, 32'h2400_0100, 32'h2800_0040, 32'h3abc_0000};
		rst_n = 1'b0;
		host_valid = 1'b0;
		host_write = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		mmio_ready = '0;
		mmio_rvalid = '0;
		mmio_rdata = '0;
		gfx_vram_valid = 1'b0;
		gfx_vram_write = 1'b0;
		gfx_vram_addr = '0;
		gfx_vram_wdata = '0;
		vdc_stream_valid = 1'b0;
		vdc_stream_write = 1'b0;
		vdc_stream_addr = '0;
		vdc_stream_wdata = '0;
		dram_ready = 1'b0;
		dram_rvalid = 1'b0;
		dram_rtag = MST_HOST;
		dram_rdata = '0;
		host_rready = 1'b1;
		rready_random = 1'b0;
		dram_hold = 1'b0;
		d_acc = 1'b0;
		m_acc = '0;
		m_done = '0;
		req_count = 0;
		rsp_count = 0;
		dram_valids = 0;
		mmio_valids = 0;
		cycles = 0;
		for (int r = 0; r < N_MMIO; r++)
			for (int k = 0; k < 16; k++) begin
				shadow_mmio[r][k] = '0;
				mmio_regs[r][k] = '0;
			end
		// 83 transactions over all tests
		limit = 20 * 83 + 8;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		cur_test = "dram_rw";
		for (int i = 0; i < 12; i++) begin
			addrs[i] = $random(seed) & 32'h1fff_fffc;
			host_req(1'b1, addrs[i], $random(seed));
		end
		for (int i = 0; i < 12; i++)
			host_req(1'b0, addrs[i], 32'd0);
		drain();

		cur_test = "mmio_rw";
		for (int r = 0; r < N_MMIO; r++)
			for (int i = 0; i < 2; i++)
				host_req(1'b1, bases[r] + 4 * i, $random(seed));
		for (int r = 0; r < N_MMIO; r++)
			for (int i = 0; i < 2; i++)
				host_req(1'b0, bases[r] + 4 * i, 32'd0);
		drain();
		for (int r = 0; r < N_MMIO; r++)
			for (int k = 0; k < 16; k++)
				check("mmio_regfile", shadow_mmio[r][k], mmio_regs[r][k]);

		cur_test = "unmapped";
		saved_dram = dram_valids;
		saved_mmio = mmio_valids;
		host_req(1'b0, 32'h4000_0000, 32'd0);
		host_req(1'b1, 32'he000_0010, 32'h1234_5678);
		drain();
		check("dram_valids", saved_dram, dram_valids);
		check("mmio_valids", saved_mmio, mmio_valids);

		cur_test = "vram_remap";
		for (int i = 0; i < 3; i++) begin
			gaddr[i] = $random(seed) & 32'hffff_fffc;
			vaddr[i] = $random(seed) & 32'hffff_fffc;
			master_access(1'b1, 1'b1, gaddr[i], $random(seed));
			master_access(1'b0, 1'b1, vaddr[i], $random(seed));
			master_access(1'b1, 1'b0, gaddr[i], 32'd0);
			master_access(1'b0, 1'b0, vaddr[i], 32'd0);
			host_req(1'b0, {VRAM_PREFIX, gaddr[i][25:0]}, 32'd0);
			host_req(1'b0, {VRAM_PREFIX, vaddr[i][25:0]}, 32'd0);
		end
		drain();

		cur_test = "priority";
		accept_log.delete();
		dram_hold = 1'b1;
		fork
			host_req(1'b0, addrs[0], 32'd0);
			master_access(1'b1, 1'b0, gaddr[0], 32'd0);
			master_access(1'b0, 1'b0, vaddr[0], 32'd0);
			begin
				repeat (8) @(negedge clk);
				dram_hold = 1'b0;
			end
		join
		drain();
		check("accept_count", 32'd3, accept_log.size());
		check("first_grant", {30'd0, MST_VDC}, {30'd0, accept_log[0]});
		check("second_grant", {30'd0, MST_HOST}, {30'd0, accept_log[1]});
		check("third_grant", {30'd0, MST_GFX}, {30'd0, accept_log[2]});

		cur_test = "backpressure";
		rready_random = 1'b1;
		for (int i = 0; i < 20; i++) begin
			sel = $unsigned($random(seed)) % 4;
			if (sel < 2)
				host_req(sel[0], addrs[i % 12], $random(seed));
			else
				host_req(sel[0], bases[i % 4] + 4 * (i % 3), $random(seed));
		end
		drain();
		rready_random = 1'b0;

		$display("All checks passed");
		$finish;
	end

endmodule

//--- sources.f
hdl/w3d_interconnect_pkg.sv
hdl/w3d_host_decode.sv
hdl/w3d_host_dispatch.sv
hdl/w3d_dram_arbiter.sv
hdl/w3d_interconnect.sv
tb/tb_w3d_interconnect.sv

//--- Makefile
# Verilator build for the w3d interconnect testbench

VERILATOR ?= verilator
TOP       ?= tb_w3d_interconnect
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= All checks passed
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
